// File: tb.f
common/i3c_pkg.sv
hw/hci/sync_fifo.sv
hw/hci/hci_csr.sv
hw/ctrl/bus_controller.sv
hw/i3c_phy.sv
hw/i3c.sv
verification/i3c_asserts.sv
verification/tb_i3c.sv

// File: run.sh
#!/bin/sh
# Builds and runs the testbench with Verilator, the exit status is the test result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_i3c -f tb.f -o sim_tb_i3c &&
  ./obj_dir/sim_tb_i3c +verilator+error+limit+100 ||
  exit 1

// File: verification/tb_i3c.sv
// Single open-drain target that ACKs every byte except the address set in nack_addr while nack_en is high
`timescale 1ns/1ps

module tb_i3c;
  import i3c_pkg::*;

  // Seven transfers of about 40 half periods of 8 cycles, plus polling and margin
  localparam int unsigned TimeoutCycles = 20000;
  localparam half_period_t HalfPeriod = 8'd7;
  localparam csr_data_t CtrlOff = {16'h0, HalfPeriod, 8'h00};
  localparam csr_data_t CtrlOn = {16'h0, HalfPeriod, 8'h01};

  logic         clk = 1'b0;
  logic         rst_n;
  csr_req_t     csr_req;
  csr_rsp_t     csr_rsp;
  logic         scl_in = 1'b1;
  logic         sda_in = 1'b1;
  logic         scl_out;
  logic         sda_out;

  // Target model
  logic         sda_pull = 1'b0;
  logic         scl_prev = 1'b1;
  logic         sda_prev = 1'b1;
  logic         bus_sda;
  logic         in_xfer = 1'b0;
  int           bit_idx = 0;
  logic [7:0]   shift;
  logic [7:0]   rx_bytes[$];
  logic         nack_en;
  target_addr_t nack_addr;

  // Expected transfers as {nack, addr, data}, expected responses in write order
  logic [15:0]  xfer_exp_q[$];
  resp_desc_t   resp_exp_q[$];
  int unsigned  cycles = 0;

  i3c DUT (
    .clk_i(clk),
    .rst_n_i(rst_n),
    .csr_req_i(csr_req),
    .csr_rsp_o(csr_rsp),
    .i3c_scl_i(scl_in),
    .i3c_scl_o(scl_out),
    .i3c_sda_i(sda_in),
    .i3c_sda_o(sda_out)
  );

  always #5 clk = ~clk;

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
    assert (got === want) else begin
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, want);
      abort_run();
    end
  endtask

  task automatic access_csr(input logic is_wr, input csr_addr_t addr, input csr_data_t wdata,
                            output csr_rsp_t rsp);
    @(posedge clk);
    #1;
    csr_req = {1'b1, is_wr, addr, wdata};
    @(posedge clk);
    #1;
    csr_req = '0;
    rsp = csr_rsp;
  endtask

  task automatic write_reg(input csr_addr_t addr, input csr_data_t wdata, output logic err);
    csr_rsp_t rsp;
    access_csr(1'b1, addr, wdata, rsp);
    compare_value("wr_ack", 32'(rsp.wr_ack), 32'h1);
    err = rsp.wr_err;
  endtask

  task automatic read_reg(input csr_addr_t addr, output csr_data_t rdata, output logic err);
    csr_rsp_t rsp;
    access_csr(1'b0, addr, '0, rsp);
    compare_value("rd_ack", 32'(rsp.rd_ack), 32'h1);
    rdata = rsp.rd_data;
    err = rsp.rd_err;
  endtask

  // Expected NACK follows the target's address rule
  task automatic push_command(input tid_t tid, input target_addr_t addr, input bus_byte_t data,
                              input logic want_err);
    logic err;
    logic nack;
    nack = nack_en && (addr == nack_addr);
    write_reg(RegCmdPort, {12'h0, tid, 1'b0, addr, data}, err);
    compare_value("cmd wr_err", 32'(err), 32'(want_err));
    if (!want_err) begin
      xfer_exp_q.push_back({nack, addr, data});
      resp_exp_q.push_back({tid, nack});
    end
  endtask

  // Poll until the response queue is non-empty, then pop and compare
  task automatic collect_response();
    csr_data_t  rdata;
    logic       err;
    resp_desc_t want;
    rdata = 32'h4;
    while (rdata[2]) begin
      read_reg(RegQueueStatus, rdata, err);
    end
    read_reg(RegRespPort, rdata, err);
    compare_value("resp rd_err", 32'(err), 32'h0);
    want = resp_exp_q.pop_front();
    compare_value("resp data", rdata, {23'h0, want.nack, 4'h0, want.tid});
  endtask

  function automatic logic ack_wanted();
    if (rx_bytes.size() == 1 && nack_en) return rx_bytes[0][7:1] != nack_addr;
    return 1'b1;
  endfunction

  // STOP follows one extra SCL rise with SDA low after the last ACK slot
  task automatic check_transfer();
    logic [15:0] want;
    if (!in_xfer || xfer_exp_q.size() == 0) begin
      $display("STOP seen without an expected transfer");
      abort_run();
    end
    want = xfer_exp_q.pop_front();
    compare_value("bits after last ACK", 32'(bit_idx), 32'h1);
    compare_value("byte count", 32'(rx_bytes.size()), want[15] ? 32'h1 : 32'h2);
    compare_value("address byte", 32'(rx_bytes[0]), 32'({want[14:8], 1'b0}));
    if (!want[15]) compare_value("data byte", 32'(rx_bytes[1]), 32'(want[7:0]));
  endtask

  // Target decodes on pin edges and pulls SDA low while SCL is low
  always @(posedge clk) begin
    #1;
    bus_sda = sda_out & ~sda_pull;
    if (scl_prev && scl_out && sda_prev && !bus_sda) begin
      if (in_xfer) begin
        $display("repeated START inside a transfer");
        abort_run();
      end
      in_xfer = 1'b1;
      bit_idx = 0;
      rx_bytes.delete();
    end else if (scl_prev && scl_out && !sda_prev && bus_sda) begin
      check_transfer();
      in_xfer = 1'b0;
    end else if (!scl_prev && scl_out && in_xfer) begin
      if (bit_idx == 8) begin
        bit_idx = 0;
      end else begin
        shift = {shift[6:0], bus_sda};
        bit_idx++;
        if (bit_idx == 8) rx_bytes.push_back(shift);
      end
    end else if (scl_prev && !scl_out) begin
      sda_pull = in_xfer && (bit_idx == 8) && ack_wanted();
    end
    scl_in = scl_out;
    sda_in = sda_out & ~sda_pull;
    scl_prev = scl_in;
    sda_prev = sda_in;
  end

  always @(negedge clk) begin
    cycles++;
    if (DUT.u_i3c_asserts.fail_cnt != 0) begin
      $display("a bound assertion failed");
      abort_run();
    end else if (cycles >= TimeoutCycles) begin
      $display("timeout after %0d cycles", cycles);
      abort_run();
    end
  end

  initial begin
    csr_data_t rdata;
    logic      err;
    void'($urandom(94));
    rst_n = 1'b1;
    csr_req = '0;
    nack_en = 1'b0;
    nack_addr = '0;
    #1;
    rst_n = 1'b0;
    repeat (16) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle bus and empty queues after reset
    compare_value("i3c_scl_o", 32'(scl_out), 32'h1);
    compare_value("i3c_sda_o", 32'(sda_out), 32'h1);
    compare_value("csr acks", 32'({csr_rsp.rd_ack, csr_rsp.wr_ack}), 32'h0);
    read_reg(RegQueueStatus, rdata, err);
    compare_value("queue status", rdata, 32'h6);

    write_reg(RegCtrl, CtrlOff, err);
    compare_value("ctrl wr_err", 32'(err), 32'h0);
    read_reg(RegCtrl, rdata, err);
    compare_value("ctrl readback", rdata, CtrlOff);
    read_reg(RegRespPort, rdata, err);
    compare_value("empty resp rd_err", 32'(err), 32'h1);
    write_reg(RegQueueStatus, 32'h1, err);
    compare_value("status wr_err", 32'(err), 32'h1);
    read_reg(RegCmdPort, rdata, err);
    compare_value("cmd port rd_err", 32'(err), 32'h1);

    // Acknowledged transfers
    write_reg(RegCtrl, CtrlOn, err);
    repeat (2) begin
      push_command(4'($urandom), 7'($urandom), 8'($urandom), 1'b0);
      collect_response();
    end

    // Address NACK skips the data byte
    nack_en = 1'b1;
    nack_addr = 7'($urandom);
    push_command(4'($urandom), nack_addr, 8'($urandom), 1'b0);
    collect_response();
    nack_en = 1'b0;

    // Fill the command queue while disabled, the fifth write is dropped
    write_reg(RegCtrl, CtrlOff, err);
    for (int i = 0; i < 5; i++) begin
      push_command(4'($urandom), 7'($urandom), 8'($urandom), i >= CmdFifoDepth);
    end
    read_reg(RegQueueStatus, rdata, err);
    compare_value("full queue status", rdata, 32'h5);
    write_reg(RegCtrl, CtrlOn, err);
    repeat (CmdFifoDepth) collect_response();
    while (xfer_exp_q.size() != 0) @(posedge clk);

    // Both queues drained with no extra response
    read_reg(RegQueueStatus, rdata, err);
    compare_value("drained queue status", rdata, 32'h6);

    $display("Test completed successfully");
    $finish;
  end

endmodule

// File: verification/i3c_asserts.sv
// CSR handshake, full queue writes and PHY delays only, as the target model checks bus framing
`timescale 1ns/1ps

module i3c_asserts (
  input logic              clk_i,
  input logic              rst_n_i,
  input i3c_pkg::csr_req_t csr_req_i,
  input i3c_pkg::csr_rsp_t csr_rsp_i,
  input logic              cmd_wready_i,
  input logic              ctrl_scl_i,
  input logic              ctrl_sda_i,
  input logic              pin_scl_i,
  input logic              pin_sda_i,
  input logic              bus_scl_i,
  input logic              bus_sda_i,
  input logic              sync_scl_i,
  input logic              sync_sda_i
);
  import i3c_pkg::*;

  // Number of failed assertions so far
  int unsigned fail_cnt = 0;

  // One ack, of one kind, in the cycle after each request
  a_ack_next: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_req_i.req |=> (csr_rsp_i.rd_ack ^ csr_rsp_i.wr_ack))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("CSR request not answered by exactly one ack");
    end

  a_no_stray_ack: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !csr_req_i.req |=> !(csr_rsp_i.rd_ack || csr_rsp_i.wr_ack))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("CSR ack without a request");
    end

  a_ack_kind: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_req_i.req && csr_req_i.is_wr |=> csr_rsp_i.wr_ack)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("CSR write answered as a read");
    end

  // Failed reads return zero
  a_err_zero: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_rsp_i.rd_err |-> (csr_rsp_i.rd_data == '0))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("read error with nonzero data");
    end

  // Command write into a full queue is rejected
  a_full_rejected: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    csr_req_i.req && csr_req_i.is_wr && (csr_req_i.addr == RegCmdPort) && !cmd_wready_i
    |=> csr_rsp_i.wr_err)
    else begin
      fail_cnt = fail_cnt + 1;
      $error("command write into a full queue not rejected");
    end

  // Controller sees the bus levels two cycles late
  a_sync_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (sync_scl_i == $past(bus_scl_i, 2)) && (sync_sda_i == $past(bus_sda_i, 2)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("synchronized levels do not follow the bus");
    end

  // Pins repeat the controller outputs one cycle later
  a_phy_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pin_scl_i == $past(ctrl_scl_i)) && (pin_sda_i == $past(ctrl_sda_i)))
    else begin
      fail_cnt = fail_cnt + 1;
      $error("pin levels do not follow the controller");
    end

endmodule

bind i3c i3c_asserts u_i3c_asserts (
  .clk_i(clk_i),
  .rst_n_i(rst_n_i),
  .csr_req_i(csr_req_i),
  .csr_rsp_i(csr_rsp_o),
  .cmd_wready_i(cmd_wready),
  .ctrl_scl_i(ctrl_scl),
  .ctrl_sda_i(ctrl_sda),
  .pin_scl_i(i3c_scl_o),
  .pin_sda_i(i3c_sda_o),
  .bus_scl_i(i3c_scl_i),
  .bus_sda_i(i3c_sda_i),
  .sync_scl_i(phy_scl),
  .sync_sda_i(phy_sda)
);

// File: hw/i3c.sv
// Open-drain write transfers of one address and one data byte only, with no interrupts
`timescale 1ns/1ps

module i3c (
  input  logic                clk_i,
  input  logic                rst_n_i,

  // CPU register access
  input  i3c_pkg::csr_req_t   csr_req_i,
  output i3c_pkg::csr_rsp_t   csr_rsp_o,

  // Pin levels equal bus levels, 0 pulls the line low
  input  logic                i3c_scl_i,
  output logic                i3c_scl_o,
  input  logic                i3c_sda_i,
  output logic                i3c_sda_o
);
  import i3c_pkg::*;

  // Command queue
  logic         cmd_wvalid;
  logic         cmd_wready;
  cmd_desc_t    cmd_wdata;
  logic         cmd_rvalid;
  logic         cmd_rready;
  cmd_desc_t    cmd_rdata;
  logic         cmd_empty;

  // Response queue
  logic         resp_wvalid;
  logic         resp_wready;
  resp_desc_t   resp_wdata;
  logic         resp_rvalid;
  logic         resp_rready;
  resp_desc_t   resp_rdata;

  logic         bus_en;
  half_period_t half_period;

  logic         ctrl_scl;
  logic         ctrl_sda;
  logic         phy_scl;
  logic         phy_sda;

  hci_csr u_hci_csr (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .csr_req_i(csr_req_i),
    .csr_rsp_o(csr_rsp_o),
    .cmd_wvalid_o(cmd_wvalid),
    .cmd_wready_i(cmd_wready),
    .cmd_wdata_o(cmd_wdata),
    .cmd_empty_i(cmd_empty),
    .resp_rvalid_i(resp_rvalid),
    .resp_rready_o(resp_rready),
    .resp_rdata_i(resp_rdata),
    .bus_en_o(bus_en),
    .half_period_o(half_period)
  );

  sync_fifo #(
    .Depth(CmdFifoDepth),
    .entry_t(cmd_desc_t)
  ) u_cmd_fifo (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .wvalid_i(cmd_wvalid),
    .wready_o(cmd_wready),
    .wdata_i(cmd_wdata),
    .rvalid_o(cmd_rvalid),
    .rready_i(cmd_rready),
    .rdata_o(cmd_rdata),
    .empty_o(cmd_empty)
  );

  // Response side reports emptiness through rvalid
  sync_fifo #(
    .Depth(RespFifoDepth),
    .entry_t(resp_desc_t)
  ) u_resp_fifo (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .wvalid_i(resp_wvalid),
    .wready_o(resp_wready),
    .wdata_i(resp_wdata),
    .rvalid_o(resp_rvalid),
    .rready_i(resp_rready),
    .rdata_o(resp_rdata),
    .empty_o()
  );

  bus_controller u_bus_controller (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .bus_en_i(bus_en),
    .half_period_i(half_period),
    .cmd_rvalid_i(cmd_rvalid),
    .cmd_rready_o(cmd_rready),
    .cmd_rdata_i(cmd_rdata),
    .resp_wvalid_o(resp_wvalid),
    .resp_wready_i(resp_wready),
    .resp_wdata_o(resp_wdata),
    .scl_o(ctrl_scl),
    .sda_o(ctrl_sda),
    .scl_i(phy_scl),
    .sda_i(phy_sda)
  );

  i3c_phy u_phy (
    .clk_i(clk_i),
    .rst_n_i(rst_n_i),
    .scl_i(i3c_scl_i),
    .sda_i(i3c_sda_i),
    .scl_o(i3c_scl_o),
    .sda_o(i3c_sda_o),
    .ctrl_scl_i(ctrl_scl),
    .ctrl_sda_i(ctrl_sda),
    .ctrl_scl_o(phy_scl),
    .ctrl_sda_o(phy_sda)
  );

endmodule

// File: hw/i3c_phy.sv
// Open-drain pins only, with one cycle of output delay and two cycles of input synchronization
`timescale 1ns/1ps

module i3c_phy (
  input  logic clk_i,
  input  logic rst_n_i,

  // Bus pins
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_o,
  output logic sda_o,

  // Controller side
  input  logic ctrl_scl_i,
  input  logic ctrl_sda_i,
  output logic ctrl_scl_o,
  output logic ctrl_sda_o
);

  // Bit 1 is SDA, bit 0 is SCL
  logic [1:0] meta_q;
  logic [1:0] sync_q;

  // Everything resets to the idle high bus level
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      {sda_o, scl_o} <= 2'b11;
      meta_q         <= 2'b11;
      sync_q         <= 2'b11;
    end else begin
      {sda_o, scl_o} <= {ctrl_sda_i, ctrl_scl_i};
      meta_q         <= {sda_i, scl_i};
      sync_q         <= meta_q;
    end
  end

  assign {ctrl_sda_o, ctrl_scl_o} = sync_q;

endmodule

// File: hw/ctrl/bus_controller.sv
// Open-drain writes only and the half-period count must be 3 or more for ACK sampling to see the target
`timescale 1ns/1ps

module bus_controller (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  logic                  bus_en_i,
  input  i3c_pkg::half_period_t half_period_i,

  // Command queue read side
  input  logic                  cmd_rvalid_i,
  output logic                  cmd_rready_o,
  input  i3c_pkg::cmd_desc_t    cmd_rdata_i,

  // Response queue write side
  output logic                  resp_wvalid_o,
  input  logic                  resp_wready_i,
  output i3c_pkg::resp_desc_t   resp_wdata_o,

  // To and from the PHY
  output logic                  scl_o,
  output logic                  sda_o,
  input  logic                  scl_i,
  input  logic                  sda_i
);
  import i3c_pkg::*;

  bus_state_e   state_q;
  logic         high_q;
  half_period_t hp_cnt_q;
  logic [2:0]   bit_cnt_q;
  logic         data_phase_q;
  logic         nack_q;
  logic         sda_q;
  logic         sda_d;
  logic         hp_done;
  logic         cmd_pop;
  bus_byte_t    shift_q;
  bus_byte_t    data_q;
  tid_t         tid_q;

  assign hp_done = (hp_cnt_q == half_period_i);

  // Start only once the synchronized bus reads free
  assign cmd_rready_o = (state_q == Idle) & bus_en_i & scl_i & sda_i;
  assign cmd_pop      = cmd_rvalid_i & cmd_rready_o;

  assign resp_wvalid_o     = (state_q == Report);
  assign resp_wdata_o.tid  = tid_q;
  assign resp_wdata_o.nack = nack_q;

  always_comb begin
    scl_o = 1'b1;
    sda_d = 1'b1;
    unique case (state_q)
      Start: sda_d = 1'b0;
      Bit: begin
        scl_o = high_q;
        sda_d = shift_q[7];
      end
      // SDA released for the target
      Ack: scl_o = high_q;
      Stop: begin
        scl_o = high_q;
        sda_d = 1'b0;
      end
      default: ;
    endcase
  end

  // SDA trails SCL by one cycle for hold time after the falling edge
  assign sda_o = sda_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q      <= Idle;
      high_q       <= 1'b0;
      hp_cnt_q     <= '0;
      bit_cnt_q    <= '0;
      data_phase_q <= 1'b0;
      nack_q       <= 1'b0;
      sda_q        <= 1'b1;
    end else begin
      sda_q <= sda_d;
      if (state_q inside {Idle, Report} || hp_done) hp_cnt_q <= '0;
      else hp_cnt_q <= hp_cnt_q + 1'b1;
      if (hp_done && state_q inside {Bit, Ack, Stop}) high_q <= ~high_q;
      unique case (state_q)
        Idle: begin
          if (cmd_pop) begin
            state_q      <= Start;
            nack_q       <= 1'b0;
            data_phase_q <= 1'b0;
          end
        end
        Start: begin
          if (hp_done) begin
            state_q   <= Bit;
            bit_cnt_q <= 3'd7;
          end
        end
        Bit: begin
          if (hp_done && high_q) begin
            if (bit_cnt_q == 3'd0) state_q <= Ack;
            else bit_cnt_q <= bit_cnt_q - 3'd1;
          end
        end
        Ack: begin
          // Sample at the end of the SCL high half
          if (hp_done && high_q) begin
            nack_q <= nack_q | sda_i;
            if (!data_phase_q && !sda_i) begin
              state_q      <= Bit;
              data_phase_q <= 1'b1;
              bit_cnt_q    <= 3'd7;
            end else begin
              state_q <= Stop;
            end
          end
        end
        Stop: begin
          if (hp_done && high_q) state_q <= Report;
        end
        Report: begin
          if (resp_wready_i) state_q <= Idle;
        end
        default: state_q <= Idle;
      endcase
    end
  end

  // Address byte carries write bit 0, sent MSB first
  always_ff @(posedge clk_i) begin
    if (cmd_pop) begin
      shift_q <= {cmd_rdata_i.addr, 1'b0};
      data_q  <= cmd_rdata_i.data;
      tid_q   <= cmd_rdata_i.tid;
    end else if (state_q == Bit && high_q && hp_done) begin
      shift_q <= {shift_q[6:0], 1'b0};
    end else if (state_q == Ack && high_q && hp_done) begin
      shift_q <= data_q;
    end
  end

endmodule

// File: hw/hci/hci_csr.sv
// Fixed one-cycle access latency with no stalls and no byte enables, so every write sets whole fields
`timescale 1ns/1ps

module hci_csr (
  input  logic                  clk_i,
  input  logic                  rst_n_i,

  input  i3c_pkg::csr_req_t     csr_req_i,
  output i3c_pkg::csr_rsp_t     csr_rsp_o,

  // Command queue write side
  output logic                  cmd_wvalid_o,
  input  logic                  cmd_wready_i,
  output i3c_pkg::cmd_desc_t    cmd_wdata_o,
  input  logic                  cmd_empty_i,

  // Response queue read side
  input  logic                  resp_rvalid_i,
  output logic                  resp_rready_o,
  input  i3c_pkg::resp_desc_t   resp_rdata_i,

  // Bus controller settings
  output logic                  bus_en_o,
  output i3c_pkg::half_period_t half_period_o
);
  import i3c_pkg::*;

  logic         bus_en_q;
  half_period_t half_period_q;
  csr_rsp_t     rsp_d;
  csr_rsp_t     rsp_q;
  logic         ctrl_we;

  // Command word layout: data 7:0, addr 14:8, tid 19:16
  assign cmd_wdata_o.data = csr_req_i.wr_data[7:0];
  assign cmd_wdata_o.addr = csr_req_i.wr_data[14:8];
  assign cmd_wdata_o.tid  = csr_req_i.wr_data[19:16];

  always_comb begin
    rsp_d         = '0;
    ctrl_we       = 1'b0;
    cmd_wvalid_o  = 1'b0;
    resp_rready_o = 1'b0;
    if (csr_req_i.req && csr_req_i.is_wr) begin
      rsp_d.wr_ack = 1'b1;
      case (csr_req_i.addr)
        RegCtrl: ctrl_we = 1'b1;
        RegCmdPort: begin
          // Full queue drops the entry
          cmd_wvalid_o = cmd_wready_i;
          rsp_d.wr_err = ~cmd_wready_i;
        end
        default: rsp_d.wr_err = 1'b1;
      endcase
    end else if (csr_req_i.req) begin
      rsp_d.rd_ack = 1'b1;
      case (csr_req_i.addr)
        RegCtrl: rsp_d.rd_data = {16'h0, half_period_q, 7'h0, bus_en_q};
        RegRespPort: begin
          if (resp_rvalid_i) begin
            resp_rready_o = 1'b1;
            rsp_d.rd_data = {23'h0, resp_rdata_i.nack, 4'h0, resp_rdata_i.tid};
          end else begin
            rsp_d.rd_err = 1'b1;
          end
        end
        RegQueueStatus: rsp_d.rd_data = {29'h0, ~resp_rvalid_i, cmd_empty_i, ~cmd_wready_i};
        // Command port is write only
        default: rsp_d.rd_err = 1'b1;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rsp_q         <= '0;
      bus_en_q      <= 1'b0;
      half_period_q <= '0;
    end else begin
      rsp_q <= rsp_d;
      if (ctrl_we) begin
        bus_en_q      <= csr_req_i.wr_data[0];
        half_period_q <= csr_req_i.wr_data[15:8];
      end
    end
  end

  assign csr_rsp_o     = rsp_q;
  assign bus_en_o      = bus_en_q;
  assign half_period_o = half_period_q;

endmodule

// File: hw/hci/sync_fifo.sv
// Depth must be a power of two and at least 2 so the pointers wrap on their own
`timescale 1ns/1ps

module sync_fifo #(
  parameter int unsigned Depth = 4,
  parameter type entry_t = logic [7:0]
) (
  input  logic   clk_i,
  input  logic   rst_n_i,

  input  logic   wvalid_i,
  output logic   wready_o,
  input  entry_t wdata_i,

  output logic   rvalid_o,
  input  logic   rready_i,
  output entry_t rdata_o,

  output logic   empty_o
);

  entry_t                   mem [Depth];
  logic [$clog2(Depth)-1:0] wr_ptr_q;
  logic [$clog2(Depth)-1:0] rd_ptr_q;
  logic [$clog2(Depth):0]   count_q;
  logic                     push;
  logic                     pop;

  assign wready_o = (count_q != ($clog2(Depth)+1)'(Depth));
  assign rvalid_o = (count_q != '0);
  assign empty_o  = ~rvalid_o;
  assign rdata_o  = mem[rd_ptr_q];

  assign push = wvalid_i & wready_o;
  assign pop  = rvalid_o & rready_i;

  always_ff @(posedge clk_i) begin
    if (push) mem[wr_ptr_q] <= wdata_i;
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop) rd_ptr_q <= rd_ptr_q + 1'b1;
      // Simultaneous push and pop keeps the count
      if (push && !pop) count_q <= count_q + 1'b1;
      else if (pop && !push) count_q <= count_q - 1'b1;
    end
  end

endmodule

// File: common/i3c_pkg.sv
// CSR offsets are byte addresses in a 16-byte window and every queue entry is a packed struct
package i3c_pkg;

  // CSR port geometry
  localparam int unsigned CsrAddrWidth = 4;
  localparam int unsigned CsrDataWidth = 32;

  typedef logic [CsrAddrWidth-1:0] csr_addr_t;
  typedef logic [CsrDataWidth-1:0] csr_data_t;

  // Register map
  localparam csr_addr_t RegCtrl        = 4'h0;
  localparam csr_addr_t RegCmdPort     = 4'h4;
  localparam csr_addr_t RegRespPort    = 4'h8;
  localparam csr_addr_t RegQueueStatus = 4'hC;

  // Queue depths, powers of two
  localparam int unsigned CmdFifoDepth  = 4;
  localparam int unsigned RespFifoDepth = 4;

  typedef logic [6:0] target_addr_t;
  typedef logic [7:0] bus_byte_t;
  typedef logic [3:0] tid_t;

  // Clock cycles per SCL half period, minus one
  typedef logic [7:0] half_period_t;

  typedef struct packed {
    logic      req;
    logic      is_wr;
    csr_addr_t addr;
    csr_data_t wr_data;
  } csr_req_t;

  typedef struct packed {
    logic      rd_ack;
    logic      rd_err;
    csr_data_t rd_data;
    logic      wr_ack;
    logic      wr_err;
  } csr_rsp_t;

  // One write transfer: address byte then one data byte
  typedef struct packed {
    tid_t         tid;
    target_addr_t addr;
    bus_byte_t    data;
  } cmd_desc_t;

  typedef struct packed {
    tid_t tid;
    logic nack;
  } resp_desc_t;

  typedef enum logic [2:0] {
    Idle,
    Start,
    Bit,
    Ack,
    Stop,
    Report
  } bus_state_e;

endpackage
